// File: verilog/i2c_proto_pkg.sv
// transfer phase encoding, phase cycle counts, default device address and r/w bit values

package i2c_proto_pkg;

    //************************************************************************
    // transfer phases, one-hot
    //************************************************************************
    typedef enum logic [7:0] {
        ph_idle    = 8'b0000_0001,  // bus free
        ph_sl_addr = 8'b0000_0010,  // START + device address, write
        ph_addr_hi = 8'b0000_0100,  // word address high byte
        ph_addr_lo = 8'b0000_1000,  // word address low byte
        ph_wr_data = 8'b0001_0000,  // data byte out
        ph_rd_addr = 8'b0010_0000,  // repeated START + device address, read
        ph_rd_data = 8'b0100_0000,  // data byte in, master NACK
        ph_stop    = 8'b1000_0000   // STOP
    } phase_t;

    //************************************************************************
    // phase lengths in dri_clk cycles
    //************************************************************************
    // four dri_clk cycles per SCL period

    localparam logic [6:0] addr_phase_cycles = 7'd40;  // START slot + 8 bits + ack
    localparam logic [6:0] byte_phase_cycles = 7'd36;  // 8 bits + ack
    localparam logic [6:0] stop_phase_cycles = 7'd17;

    //************************************************************************
    // device addressing
    //************************************************************************
    localparam logic [6:0] default_slave_addr = 7'h3c;

    localparam logic wr_bit = 1'b0;
    localparam logic rd_bit = 1'b1;

endpackage

// File: verilog/i2c_cmd_pkg.sv
// user command struct, engine report struct, data and word address widths

package i2c_cmd_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 16;

    //************************************************************************
    // one EEPROM access as given by the caller
    //************************************************************************
    typedef struct packed {
        logic              rd;      // 1 = random read, 0 = byte write
        logic              addr16;  // two word address bytes
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } i2c_cmd_t;

    //************************************************************************
    // bit engine status, once per phase
    //************************************************************************
    typedef struct packed {
        logic              phase_done;  // last cycle of the phase
        logic              nack;        // SDA level in the ack slot
        logic [data_w-1:0] rx_byte;     // shifted in during read data
    } eng_report_t;

endpackage

// File: verilog/i2c_cmd_sequencer.sv
// i2c_cmd_sequencer module, command capture and phase sequencing

`timescale 1ns/100ps

module i2c_cmd_sequencer #(
    parameter logic [6:0] slave_addr = i2c_proto_pkg::default_slave_addr
) (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  logic                        i2c_exec,
    input  i2c_cmd_pkg::i2c_cmd_t       cmd,
    input  i2c_cmd_pkg::eng_report_t    report,
    output i2c_proto_pkg::phase_t       phase,
    output logic [i2c_cmd_pkg::data_w-1:0] tx_byte,
    output logic                        accept
);

    i2c_proto_pkg::phase_t phase_nxt;
    i2c_cmd_pkg::i2c_cmd_t cmd_q;   // held for the whole transfer

    // strobes outside idle are dropped
    assign accept = (phase == i2c_proto_pkg::ph_idle) && i2c_exec;

    always_ff @(posedge dri_clk) begin
        if (accept)
            cmd_q <= cmd;
    end

    //************************************************************************
    // phase transitions
    //************************************************************************
    always_comb begin
        phase_nxt = phase;
        case (phase)
            i2c_proto_pkg::ph_idle:
                if (accept)
                    phase_nxt = i2c_proto_pkg::ph_sl_addr;
            i2c_proto_pkg::ph_sl_addr:
                if (report.phase_done) begin
                    if (cmd_q.addr16)
                        phase_nxt = i2c_proto_pkg::ph_addr_hi;
                    else
                        phase_nxt = i2c_proto_pkg::ph_addr_lo;
                end
            i2c_proto_pkg::ph_addr_hi:
                if (report.phase_done)
                    phase_nxt = i2c_proto_pkg::ph_addr_lo;
            i2c_proto_pkg::ph_addr_lo:
                if (report.phase_done) begin
                    if (cmd_q.rd)
                        phase_nxt = i2c_proto_pkg::ph_rd_addr;
                    else
                        phase_nxt = i2c_proto_pkg::ph_wr_data;
                end
            i2c_proto_pkg::ph_wr_data,
            i2c_proto_pkg::ph_rd_data:
                if (report.phase_done)
                    phase_nxt = i2c_proto_pkg::ph_stop;
            i2c_proto_pkg::ph_rd_addr:
                if (report.phase_done)
                    phase_nxt = i2c_proto_pkg::ph_rd_data;
            i2c_proto_pkg::ph_stop:
                if (report.phase_done)
                    phase_nxt = i2c_proto_pkg::ph_idle;
            default: phase_nxt = i2c_proto_pkg::ph_idle;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            phase <= i2c_proto_pkg::ph_idle;
        else
            phase <= phase_nxt;
    end

    // byte the engine puts on the bus in this phase
    always_comb begin
        case (phase)
            i2c_proto_pkg::ph_sl_addr: tx_byte = {slave_addr, i2c_proto_pkg::wr_bit};
            i2c_proto_pkg::ph_rd_addr: tx_byte = {slave_addr, i2c_proto_pkg::rd_bit};
            i2c_proto_pkg::ph_addr_hi: tx_byte = cmd_q.addr[15:8];
            i2c_proto_pkg::ph_addr_lo: tx_byte = cmd_q.addr[7:0];
            i2c_proto_pkg::ph_wr_data: tx_byte = cmd_q.wdata;
            default:                   tx_byte = '1;  // bus released
        endcase
    end

    a_phase_onehot: assert property (@(posedge dri_clk) disable iff (!rst_n)
        $onehot(phase));

endmodule

// File: verilog/i2c_bit_engine.sv
// i2c_bit_engine module, SCL/SDA slot timing, bit shifting and ack sampling

`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic                            dri_clk,
    input  logic                            rst_n,
    input  i2c_proto_pkg::phase_t           phase,
    input  logic [i2c_cmd_pkg::data_w-1:0]  tx_byte,
    input  logic                            sda_i,
    output logic                            scl,
    output logic                            sda_o,
    output logic                            sda_oe,
    output i2c_cmd_pkg::eng_report_t        report
);

    logic [6:0] cnt;          // cycle within phase
    logic [6:0] phase_len;
    logic [6:0] bit_base;     // first data bit slot
    logic [6:0] rel;
    logic       is_addr;      // phase opens with (repeated) START
    logic       is_read;
    logic       in_byte;      // any of the six byte phases
    logic       start_slot;
    logic       ack_slot;
    logic       bit_slot;
    logic       phase_done;
    logic       nack;
    logic [i2c_cmd_pkg::data_w-1:0] rx_byte;

    assign is_addr = (phase == i2c_proto_pkg::ph_sl_addr) ||
                     (phase == i2c_proto_pkg::ph_rd_addr);
    assign is_read = (phase == i2c_proto_pkg::ph_rd_data);
    assign in_byte = (phase != i2c_proto_pkg::ph_idle) && (phase != i2c_proto_pkg::ph_stop);

    assign phase_len = is_addr ? i2c_proto_pkg::addr_phase_cycles
                               : i2c_proto_pkg::byte_phase_cycles;
    assign bit_base  = is_addr ? 7'd4 : 7'd0;
    assign rel       = cnt - bit_base;

    assign start_slot = is_addr && (cnt < 7'd4);
    assign ack_slot   = cnt >= (phase_len - 7'd4);
    assign bit_slot   = in_byte && !start_slot && !ack_slot;

    //************************************************************************
    // SCL / SDA slots, 4 cycles per bit
    //************************************************************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= 7'd0;
            scl        <= 1'b1;
            sda_o      <= 1'b1;
            sda_oe     <= 1'b1;
            phase_done <= 1'b0;
        end else begin
            cnt        <= cnt + 7'd1;
            phase_done <= 1'b0;
            if (phase == i2c_proto_pkg::ph_idle) begin
                cnt    <= 7'd0;
                scl    <= 1'b1;
                sda_o  <= 1'b1;
                sda_oe <= 1'b1;
            end else if (phase == i2c_proto_pkg::ph_stop) begin
                case (cnt)
                    7'd0: begin
                        sda_oe <= 1'b1;
                        sda_o  <= 1'b0;
                    end
                    7'd1: scl <= 1'b1;
                    7'd3: sda_o <= 1'b1;  // STOP
                    default: ;
                endcase
                if (cnt == i2c_proto_pkg::stop_phase_cycles - 7'd2)
                    phase_done <= 1'b1;
                if (cnt == i2c_proto_pkg::stop_phase_cycles - 7'd1)
                    cnt <= 7'd0;
            end else if (start_slot) begin
                case (cnt[1:0])
                    2'd0: if (!(phase == i2c_proto_pkg::ph_sl_addr)) begin
                        sda_oe <= 1'b1;
                        sda_o  <= 1'b1;
                    end
                    2'd1: if (phase == i2c_proto_pkg::ph_sl_addr)
                        sda_o <= 1'b0;  // START, SCL still high from idle
                    else
                        scl <= 1'b1;
                    2'd2: if (phase == i2c_proto_pkg::ph_rd_addr)
                        sda_o <= 1'b0;  // repeated START
                    default: scl <= 1'b0;
                endcase
            end else if (bit_slot) begin
                case (cnt[1:0])
                    2'd0: if (is_read)
                        sda_oe <= 1'b0;
                    else begin
                        sda_oe <= 1'b1;
                        sda_o  <= tx_byte[~rel[4:2]];  // MSB first
                    end
                    2'd1: scl <= 1'b1;
                    2'd3: scl <= 1'b0;
                    default: ;
                endcase
            end else begin
                case (cnt[1:0])
                    2'd0: begin
                        sda_oe <= is_read;  // master NACK after read, else release
                        sda_o  <= 1'b1;
                    end
                    2'd1: scl <= 1'b1;
                    2'd2: phase_done <= 1'b1;
                    default: begin
                        scl <= 1'b0;
                        cnt <= 7'd0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge dri_clk) begin
        if (bit_slot && is_read && (cnt[1:0] == 2'd1))
            rx_byte <= {rx_byte[6:0], sda_i};
        if (in_byte && (cnt == phase_len - 7'd2))
            nack <= sda_i;  // high = no acknowledge
    end

    assign report = '{phase_done: phase_done, nack: nack, rx_byte: rx_byte};

    // data may only move under SCL high for START, repeated START and STOP
    a_sda_scl_high: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (scl && $past(scl) && sda_oe && (sda_o != $past(sda_o)))
            |-> ($past(phase) inside {i2c_proto_pkg::ph_sl_addr,
                                      i2c_proto_pkg::ph_rd_addr,
                                      i2c_proto_pkg::ph_stop}));

    a_no_done_idle: assert property (@(posedge dri_clk) disable iff (!rst_n)
        phase_done |-> (phase != i2c_proto_pkg::ph_idle));

endmodule

// File: verilog/i2c_result_collect.sv
// i2c_result_collect module, sticky ack flag, read byte and done pulse

`timescale 1ns/100ps

module i2c_result_collect (
    input  logic                            dri_clk,
    input  logic                            rst_n,
    input  i2c_proto_pkg::phase_t           phase,
    input  logic                            accept,
    input  i2c_cmd_pkg::eng_report_t        report,
    output logic [i2c_cmd_pkg::data_w-1:0]  i2c_data_r,
    output logic                            i2c_ack,
    output logic                            i2c_done
);

    logic wr_dir;   // slave drives the ack bit

    assign wr_dir = phase inside {i2c_proto_pkg::ph_sl_addr, i2c_proto_pkg::ph_addr_hi,
                                  i2c_proto_pkg::ph_addr_lo, i2c_proto_pkg::ph_wr_data,
                                  i2c_proto_pkg::ph_rd_addr};

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_ack    <= 1'b0;
            i2c_done   <= 1'b0;
            i2c_data_r <= '0;
        end else begin
            i2c_done <= report.phase_done && (phase == i2c_proto_pkg::ph_stop);
            if (accept)
                i2c_ack <= 1'b0;  // new command
            else if (report.phase_done && report.nack && wr_dir)
                i2c_ack <= 1'b1;
            if (report.phase_done && (phase == i2c_proto_pkg::ph_rd_data))
                i2c_data_r <= report.rx_byte;
        end
    end

    a_done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done);

endmodule

// File: verilog/i2c_master.sv
// i2c_master top level, sequencer, bit engine and result collector

`timescale 1ns/100ps

module i2c_master #(
    parameter logic [6:0] slave_addr = i2c_proto_pkg::default_slave_addr
) (
    input  logic                            dri_clk,
    input  logic                            rst_n,
    input  logic                            i2c_exec,     // start strobe
    input  logic                            bit_ctrl,     // 1 = 16-bit word address
    input  logic                            i2c_rh_wl,    // 1 = read
    input  logic [i2c_cmd_pkg::addr_w-1:0]  i2c_addr,
    input  logic [i2c_cmd_pkg::data_w-1:0]  i2c_data_w,
    output logic [i2c_cmd_pkg::data_w-1:0]  i2c_data_r,
    output logic                            i2c_done,
    output logic                            i2c_ack,      // 1 = NACK seen
    output logic                            scl,
    output logic                            sda_o,
    output logic                            sda_oe,
    input  logic                            sda_i         // resolved line
);

    i2c_cmd_pkg::i2c_cmd_t    cmd;
    i2c_cmd_pkg::eng_report_t report;
    i2c_proto_pkg::phase_t    phase;
    logic [i2c_cmd_pkg::data_w-1:0] tx_byte;
    logic                     accept;

    assign cmd = '{rd: i2c_rh_wl, addr16: bit_ctrl, addr: i2c_addr, wdata: i2c_data_w};

    i2c_cmd_sequencer #(.slave_addr(slave_addr)) u_seq (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .i2c_exec(i2c_exec),
        .cmd     (cmd),
        .report  (report),
        .phase   (phase),
        .tx_byte (tx_byte),
        .accept  (accept)
    );

    i2c_bit_engine u_eng (
        .dri_clk(dri_clk),
        .rst_n  (rst_n),
        .phase  (phase),
        .tx_byte(tx_byte),
        .sda_i  (sda_i),
        .scl    (scl),
        .sda_o  (sda_o),
        .sda_oe (sda_oe),
        .report (report)
    );

    i2c_result_collect u_res (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .accept    (accept),
        .report    (report),
        .i2c_data_r(i2c_data_r),
        .i2c_ack   (i2c_ack),
        .i2c_done  (i2c_done)
    );

endmodule

// File: verification/i2c_eeprom_model.sv
// i2c_eeprom_model module, behavioral I2C EEPROM slave with 64 K byte memory

`timescale 1ns/100ps

module i2c_eeprom_model #(
    parameter logic [6:0] dev_addr = 7'h3c
) (
    input  logic scl,
    input  logic sda,
    input  logic respond,   // 0 = never acknowledge
    input  logic addr16,    // two word address bytes
    output logic pull       // 1 = drive SDA low
);

    localparam int s_idle   = 0;
    localparam int s_dev    = 1;
    localparam int s_ahi    = 2;
    localparam int s_alo    = 3;
    localparam int s_wdata  = 4;
    localparam int s_tx_ack = 5;   // acking a read address
    localparam int s_tx     = 6;   // sending a data byte

    logic [7:0]  mem [0:65535];
    logic [7:0]  shift = 8'h00;
    logic [7:0]  tx = 8'hff;
    logic [15:0] ptr = 16'h0000;
    logic        pull_q = 1'b0;
    logic        scl_q = 1'b1;
    logic        sda_q = 1'b1;
    int          state = s_idle;
    int          bit_cnt = 0;  // SCL rises seen in this frame

    assign pull = pull_q;

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'h5a;
    endfunction

    initial begin
        for (int i = 0; i < 65536; i++)
            mem[16'(i)] = fill_byte(16'(i));
    end

    //************************************************************************
    // bus events
    //************************************************************************
    always begin
        @(scl or sda);
        if (sda !== sda_q && scl_q === 1'b1 && scl === 1'b1) begin
            pull_q = 1'b0;
            if (sda === 1'b0) begin
                state   = s_dev;   // START or repeated START
                bit_cnt = 0;
            end else begin
                state = s_idle;    // STOP
            end
        end else if (scl !== scl_q && scl === 1'b1) begin
            if (state != s_idle) begin
                if (bit_cnt < 8)
                    shift = {shift[6:0], sda};
                bit_cnt++;
            end
        end else if (scl !== scl_q && scl === 1'b0 && state != s_idle) begin
            if (bit_cnt == 8) begin
                if (state == s_tx) begin
                    pull_q = 1'b0;  // master acks or nacks
                end else begin
                    case (state)
                        s_dev: begin
                            if (shift[7:1] == dev_addr && respond) begin
                                pull_q = 1'b1;
                                if (shift[0]) begin
                                    state = s_tx_ack;
                                    tx    = mem[ptr];
                                    ptr   = ptr + 16'd1;
                                end else begin
                                    state = addr16 ? s_ahi : s_alo;
                                end
                            end else begin
                                state = s_idle;
                            end
                        end
                        s_ahi: begin
                            ptr[15:8] = shift;
                            pull_q    = 1'b1;
                            state     = s_alo;
                        end
                        s_alo: begin
                            if (!addr16)
                                ptr[15:8] = 8'h00;
                            ptr[7:0] = shift;
                            pull_q   = 1'b1;
                            state    = s_wdata;
                        end
                        s_wdata: begin
                            mem[ptr] = shift;
                            ptr      = ptr + 16'd1;
                            pull_q   = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end else if (bit_cnt == 9) begin
                bit_cnt = 0;
                pull_q  = 1'b0;
                if (state == s_tx_ack) begin
                    state  = s_tx;
                    pull_q = !tx[7];  // first data bit
                end else if (state == s_tx) begin
                    state = s_idle;
                end
            end else if (state == s_tx && bit_cnt > 0) begin
                pull_q = !tx[3'(7 - bit_cnt)];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: verification/tb_i2c_master.sv
// tb_i2c_master testbench, clock, reset, SDA resolution, stimulus table and checks

`timescale 1ns/100ps

module tb_i2c_master;

    localparam int n_tests = 12;
    localparam int done_timeout = 400;

    typedef struct packed {
        logic                           rd;
        logic                           addr16;
        logic [i2c_cmd_pkg::addr_w-1:0] addr;
        logic [i2c_cmd_pkg::data_w-1:0] wdata;
        logic                           respond;
        logic                           busy_poke;  // extra strobe mid-transfer
        logic [i2c_cmd_pkg::data_w-1:0] exp_data;
        logic                           exp_ack;
    } entry_t;

    logic                           dri_clk = 1'b0;
    logic                           rst_n;
    logic                           i2c_exec;
    logic                           bit_ctrl;
    logic                           i2c_rh_wl;
    logic [i2c_cmd_pkg::addr_w-1:0] i2c_addr;
    logic [i2c_cmd_pkg::data_w-1:0] i2c_data_w;
    logic [i2c_cmd_pkg::data_w-1:0] i2c_data_r;
    logic                           i2c_done;
    logic                           i2c_ack;
    logic                           scl;
    logic                           sda_o;
    logic                           sda_oe;
    logic                           sda;
    logic                           pull;
    logic                           respond;
    logic                           model_addr16;
    logic [7:0]                     shadow [0:65535];
    entry_t                         table_q [0:n_tests-1];
    int                             done_count;

    always #2 dri_clk = ~dri_clk;

    assign sda = sda_oe ? sda_o : !pull;  // open drain with pull-up

    always @(posedge dri_clk) begin
        if (!rst_n)
            done_count <= 0;
        else if (i2c_done === 1'b1)
            done_count <= done_count + 1;
    end

    i2c_master dut (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .i2c_exec  (i2c_exec),
        .bit_ctrl  (bit_ctrl),
        .i2c_rh_wl (i2c_rh_wl),
        .i2c_addr  (i2c_addr),
        .i2c_data_w(i2c_data_w),
        .i2c_data_r(i2c_data_r),
        .i2c_done  (i2c_done),
        .i2c_ack   (i2c_ack),
        .scl       (scl),
        .sda_o     (sda_o),
        .sda_oe    (sda_oe),
        .sda_i     (sda)
    );

    i2c_eeprom_model #(.dev_addr(i2c_proto_pkg::default_slave_addr)) eeprom (
        .scl    (scl),
        .sda    (sda),
        .respond(respond),
        .addr16 (model_addr16),
        .pull   (pull)
    );

    function automatic logic [7:0] initial_byte(input logic [15:0] a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'h5a;
    endfunction

    function automatic entry_t make_entry(input logic rd, input logic a16,
                                          input logic [15:0] addr, input logic resp,
                                          input logic poke);
        entry_t e;
        e           = '0;
        e.rd        = rd;
        e.addr16    = a16;
        e.addr      = addr;
        e.wdata     = 8'($urandom);
        e.respond   = resp;
        e.busy_poke = poke;
        return e;
    endfunction

    task automatic tick();
        @(posedge dri_clk);
        #1;
    endtask

    initial begin
        entry_t      e;
        logic [15:0] key;
        int          errors;
        int          test_errs;
        int          passed;
        int          cnt_before;
        int          waited;
        bit          seen;

        errors = 0;
        passed = 0;
        void'($urandom(32'h94d3));
        rst_n        = 1'b0;
        i2c_exec     = 1'b0;
        bit_ctrl     = 1'b0;
        i2c_rh_wl    = 1'b0;
        i2c_addr     = '0;
        i2c_data_w   = '0;
        respond      = 1'b1;
        model_addr16 = 1'b0;
        for (int i = 0; i < 65536; i++)
            shadow[16'(i)] = initial_byte(16'(i));

        //********************************************************************
        // stimulus table
        //********************************************************************
        table_q[0]  = make_entry(1'b0, 1'b0, 16'h0021, 1'b1, 1'b0);
        table_q[1]  = make_entry(1'b1, 1'b0, 16'h0021, 1'b1, 1'b0);
        table_q[2]  = make_entry(1'b0, 1'b1, 16'h1234, 1'b1, 1'b0);
        table_q[3]  = make_entry(1'b0, 1'b1, 16'h5634, 1'b1, 1'b0);  // high byte only differs
        table_q[4]  = make_entry(1'b1, 1'b1, 16'h1234, 1'b1, 1'b0);
        table_q[5]  = make_entry(1'b1, 1'b1, 16'h5634, 1'b1, 1'b0);
        table_q[6]  = make_entry(1'b0, 1'b0, 16'h0040, 1'b0, 1'b0);  // no ack
        table_q[7]  = make_entry(1'b1, 1'b0, 16'h0040, 1'b0, 1'b0);
        table_q[8]  = make_entry(1'b1, 1'b0, 16'h0021, 1'b1, 1'b0);  // flag clears
        table_q[9]  = make_entry(1'b0, 1'b1, 16'h0300, 1'b1, 1'b1);
        table_q[10] = make_entry(1'b1, 1'b1, 16'h0777, 1'b1, 1'b0);  // poke target
        table_q[11] = make_entry(1'b1, 1'b1, 16'h0300, 1'b1, 1'b0);

        repeat (4) @(posedge dri_clk);
        #1 rst_n = 1'b1;
        tick();

        test_errs = 0;
        assert (scl && sda_oe && sda_o && !i2c_done && !i2c_ack) else begin
            $display("ERR reset state: scl %h sda_oe %h sda_o %h i2c_done %h i2c_ack %h",
                     scl, sda_oe, sda_o, i2c_done, i2c_ack);
            test_errs++;
        end
        $display("reset check: %s", (test_errs == 0) ? "ok" : "FAILED");
        errors += test_errs;

        for (int t = 0; t < n_tests; t++) begin
            e   = table_q[t];
            key = e.addr16 ? e.addr : {8'h00, e.addr[7:0]};
            e.exp_ack  = !e.respond;
            e.exp_data = e.respond ? shadow[key] : 8'hff;
            if (!e.rd && e.respond)
                shadow[key] = e.wdata;
            table_q[t] = e;
            test_errs  = 0;

            respond      = e.respond;
            model_addr16 = e.addr16;
            bit_ctrl     = e.addr16;
            i2c_rh_wl    = e.rd;
            i2c_addr     = e.addr;
            i2c_data_w   = e.wdata;
            cnt_before   = done_count;
            i2c_exec     = 1'b1;
            tick();
            i2c_exec = 1'b0;

            if (e.busy_poke) begin
                waited = 0;
                while (waited < 60 && !i2c_done) begin
                    tick();
                    waited++;
                end
                assert (!i2c_done) else begin
                    $display("test %0d: command ended before the busy strobe", t);
                    test_errs++;
                end
                i2c_addr   = e.addr ^ 16'h0477;
                i2c_data_w = ~e.wdata;
                i2c_exec   = 1'b1;
                tick();
                i2c_exec   = 1'b0;
                i2c_addr   = e.addr;
                i2c_data_w = e.wdata;
            end

            // wait for done
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < done_timeout) begin
                tick();
                waited++;
                seen = i2c_done;
            end
            if (!seen) begin
                $display("test %0d: no i2c_done within %0d cycles", t, done_timeout);
                $display("Test failed");
                $finish;
            end

            assert (i2c_ack == e.exp_ack) else begin
                $display("ERR i2c_ack: got %h expected %h", i2c_ack, e.exp_ack);
                test_errs++;
            end
            if (e.rd) begin
                assert (i2c_data_r == e.exp_data) else begin
                    $display("ERR i2c_data_r: got %h expected %h", i2c_data_r, e.exp_data);
                    test_errs++;
                end
            end
            tick();
            assert (!i2c_done) else begin
                $display("test %0d: i2c_done held high for more than one cycle", t);
                test_errs++;
            end
            tick();
            assert (done_count - cnt_before == 1) else begin
                $display("test %0d: expected one i2c_done pulse, saw %0d", t,
                         done_count - cnt_before);
                test_errs++;
            end

            $display("test %0d %s addr %h: %s", t, e.rd ? "read " : "write", e.addr,
                     (test_errs == 0) ? "ok" : "FAILED");
            if (test_errs == 0)
                passed++;
            errors += test_errs;
        end

        $display("%0d of %0d tests ok, %0d failed checks", passed, n_tests, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: project.f
verilog/i2c_proto_pkg.sv
verilog/i2c_cmd_pkg.sv
verilog/i2c_cmd_sequencer.sv
verilog/i2c_bit_engine.sv
verilog/i2c_result_collect.sv
verilog/i2c_master.sv
verification/i2c_eeprom_model.sv
verification/tb_i2c_master.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_i2c_master -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
